/* icache.f */
+incdir+common
common/icache_pkg.sv
source/set_ram.sv
icache/icache_way.sv
icache/icache_ctrl.sv
icache/icache_refill.sv
source/icache_top.sv
test/tb_axil_mem.sv
test/tb_icache.sv

/* Makefile */
# Verilator build and run for the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= icache.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard common/*.svh)
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := all tests passed

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, a header or the file list changes
$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status comes from the grep on the simulator output
run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_icache.sv */
//##########################################################
// tb_icache
// testbench for the two-way instruction cache, table of
// fetches with expected words, errors and ar beat counts
//##########################################################
`timescale 1ns/1ps

module tb_icache;

    localparam logic [31:0] SEED        = 32'h62e3fdb8;
    localparam logic [31:0] PAT_KEY     = 32'h5a5a0f0f;
    localparam logic [31:0] ERR_LO      = 32'h00008000;
    localparam logic [31:0] ERR_HI      = 32'h0000800f;
    localparam int          N_ROWS      = 17;
    localparam int          CYCLE_LIMIT = 40 * N_ROWS + 100;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        flush;
    logic        req_valid;
    logic [31:0] req_addr;
    logic        req_ready;
    logic        resp_valid;
    logic [31:0] resp_data;
    logic        resp_err;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic [31:0] ar_count;

    // stimulus table, one fetch per row
    logic [31:0] row_addr  [N_ROWS];
    logic        row_flush [N_ROWS];  // pulse flush before the fetch
    logic [31:0] row_word  [N_ROWS];
    logic        row_err   [N_ROWS];
    logic [31:0] row_ar    [N_ROWS];  // ar handshakes expected, 0 or 4

    int   cycle_count = 0;
    int   check_errors = 0;
    int   tests_run = 0;
    int   tests_bad = 0;
    logic test_bad;

    always #2 clk = ~clk;  // 4 ns period

    icache_top uut (
        .clk_i(clk), .rst_n_i(rst_n), .flush_i(flush),
        .req_valid_i(req_valid), .req_addr_i(req_addr), .req_ready_o(req_ready),
        .resp_valid_o(resp_valid), .resp_data_o(resp_data), .resp_err_o(resp_err),
        .m_arvalid_o(arvalid), .m_arready_i(arready), .m_araddr_o(araddr),
        .m_rvalid_i(rvalid), .m_rready_o(rready),
        .m_rdata_i(rdata), .m_rresp_i(rresp));

    tb_axil_mem #(.SEED(SEED), .PAT_KEY(PAT_KEY), .ERR_LO(ERR_LO), .ERR_HI(ERR_HI)) mem (
        .clk_i(clk), .rst_n_i(rst_n),
        .arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr),
        .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata), .rresp_o(rresp),
        .ar_count_o(ar_count));

    // run limit, scaled to the table length
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: cache gave no response within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] pattern_word(input logic [31:0] addr);
        pattern_word = {addr[31:2], 2'b00} ^ PAT_KEY;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at time %0t: %s, got %h expected %h", $time, what, got, exp);
            check_errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (test_bad) begin
            tests_bad++;
        end
        $display("test %0d %s: %s", tests_run, name, test_bad ? "FAIL" : "ok");
    endtask

    task automatic set_row(input int i, input logic [31:0] addr, input logic fl,
                           input logic [31:0] word, input logic err, input logic [31:0] ar);
        row_addr[i]  = addr;
        row_flush[i] = fl;
        row_word[i]  = word;
        row_err[i]   = err;
        row_ar[i]    = ar;
    endtask

    // set 5 lines A 0x050, B 0x450, C 0x850
    task automatic load_table();
        set_row(0,  32'h0000_1000, 1'b0, pattern_word(32'h0000_1000), 1'b0, 4);  // cold miss
        set_row(1,  32'h0000_1004, 1'b0, pattern_word(32'h0000_1004), 1'b0, 0);
        set_row(2,  32'h0000_100c, 1'b0, pattern_word(32'h0000_100c), 1'b0, 0);
        set_row(3,  32'h0000_0050, 1'b0, pattern_word(32'h0000_0050), 1'b0, 4);  // A
        set_row(4,  32'h0000_0454, 1'b0, pattern_word(32'h0000_0454), 1'b0, 4);  // B
        set_row(5,  32'h0000_0058, 1'b0, pattern_word(32'h0000_0058), 1'b0, 0);  // B now lru
        set_row(6,  32'h0000_0850, 1'b0, pattern_word(32'h0000_0850), 1'b0, 4);  // C evicts B
        set_row(7,  32'h0000_005c, 1'b0, pattern_word(32'h0000_005c), 1'b0, 0);
        set_row(8,  32'h0000_0450, 1'b0, pattern_word(32'h0000_0450), 1'b0, 4);  // B gone
        set_row(9,  32'h0000_0054, 1'b0, pattern_word(32'h0000_0054), 1'b0, 0);
        set_row(10, 32'h0000_1008, 1'b0, pattern_word(32'h0000_1008), 1'b0, 0);
        set_row(11, 32'h0000_1008, 1'b1, pattern_word(32'h0000_1008), 1'b0, 4);  // after flush
        set_row(12, 32'h0000_0050, 1'b0, pattern_word(32'h0000_0050), 1'b0, 4);
        set_row(13, 32'h0000_8004, 1'b0, 32'h0, 1'b1, 4);  // slverr window
        set_row(14, 32'h0000_8004, 1'b0, 32'h0, 1'b1, 4);  // not installed, misses again
        set_row(15, 32'h0000_800c, 1'b0, 32'h0, 1'b1, 4);
        set_row(16, 32'h0000_1000, 1'b0, pattern_word(32'h0000_1000), 1'b0, 0);
    endtask

    task automatic check_reset_state();
        test_bad = 1'b0;
        check_value("req_ready after reset", 32'(req_ready), 32'd1);
        check_value("resp_valid after reset", 32'(resp_valid), 32'd0);
        check_value("arvalid after reset", 32'(arvalid), 32'd0);
        check_value("rready after reset", 32'(rready), 32'd0);
        report_test("reset state");
    endtask

    task automatic run_row(input int r);
        logic [31:0] ar_before;
        int          waited;
        test_bad = 1'b0;
        if (row_flush[r]) begin
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
        end
        while (!req_ready) @(negedge clk);
        ar_before = ar_count;
        req_valid = 1'b1;
        req_addr  = row_addr[r];
        @(negedge clk);  // accepted at the rising edge just passed
        req_valid = 1'b0;
        waited = 0;
        while (!resp_valid) begin
            @(negedge clk);
            waited++;
        end
        if (!row_err[r]) begin
            check_value("read data", resp_data, row_word[r]);  // data undefined on error
        end
        check_value("error flag", 32'(resp_err), 32'(row_err[r]));
        check_value("ar beats", ar_count - ar_before, row_ar[r]);
        if (row_ar[r] == 32'd0) begin
            check_value("hit latency", waited, 32'd0);  // one cycle after accept
        end
        report_test($sformatf("fetch %h", row_addr[r]));
    endtask

    // back-to-back hits on a resident line
    task automatic hit_burst(input logic [31:0] base);
        logic [31:0] ar_before;
        logic [31:0] addr;
        test_bad = 1'b0;
        while (!req_ready) @(negedge clk);
        ar_before = ar_count;
        for (int k = 0; k < 4; k++) begin
            addr      = base + 32'(4 * k);
            req_valid = 1'b1;
            req_addr  = addr;
            @(negedge clk);
            check_value("burst resp_valid", 32'(resp_valid), 32'd1);
            check_value("burst data", resp_data, pattern_word(addr));
            check_value("burst req_ready", 32'(req_ready), 32'd1);
        end
        req_valid = 1'b0;
        check_value("burst ar beats", ar_count - ar_before, 32'd0);
        report_test($sformatf("hit burst %h", base));
    endtask

    initial begin
        rst_n     = 1'b0;
        flush     = 1'b0;
        req_valid = 1'b0;
        req_addr  = '0;
        load_table();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        check_reset_state();
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        hit_burst(32'h0000_1000);
        $display("summary: %0d tests, %0d with errors, %0d check mismatches",
                 tests_run, tests_bad, check_errors);
        if (check_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* test/tb_axil_mem.sv */
//##########################################################
// tb_axil_mem
// axi4-lite read-only memory model for the cache testbench
// pattern data, random ready stalls, slverr address window
//##########################################################
`timescale 1ns/1ps

module tb_axil_mem #(
    parameter logic [31:0] SEED    = 32'h62e3fdb8,
    parameter logic [31:0] PAT_KEY = 32'h5a5a0f0f,
    parameter logic [31:0] ERR_LO  = 32'h00008000,
    parameter logic [31:0] ERR_HI  = 32'h0000800f
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        arvalid_i,
    output logic        arready_o,
    input  logic [31:0] araddr_i,
    output logic        rvalid_o,
    input  logic        rready_i,
    output logic [31:0] rdata_o,
    output logic [1:0]  rresp_o,
    output logic [31:0] ar_count_o
);

    integer      seed;
    logic        live_q;        // reset released as of the last rising edge
    logic        pend_q;        // address taken but data not yet returned
    logic [31:0] pend_addr_q;
    logic [31:0] ar_count_q;    // ar handshakes since reset

    assign ar_count_o = ar_count_q;

    // ready three cycles in four
    function automatic logic draw_ready();
        draw_ready = ($random(seed) & 3) != 0;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        read_word = {addr[31:2], 2'b00} ^ PAT_KEY;  // memory content rule
    endfunction

    function automatic logic in_err_window(input logic [31:0] addr);
        in_err_window = (addr >= ERR_LO) && (addr <= ERR_HI);
    endfunction

    // handshakes seen at the rising edge
    always @(posedge clk_i) begin
        live_q <= rst_n_i;
        if (!rst_n_i) begin
            pend_q     <= 1'b0;
            ar_count_q <= '0;
        end else begin
            if (arvalid_i && arready_o) begin
                pend_q      <= 1'b1;
                pend_addr_q <= araddr_i;
                ar_count_q  <= ar_count_q + 32'd1;
            end else if (rvalid_o && rready_i) begin
                pend_q <= 1'b0;  // beat delivered
            end
        end
    end

    // outputs change on the falling edge only
    initial begin
        seed      = SEED;
        arready_o = 1'b0;
        rvalid_o  = 1'b0;
        rdata_o   = '0;
        rresp_o   = 2'b00;
        forever begin
            @(negedge clk_i);
            if (!live_q || !pend_q) begin
                rvalid_o  = 1'b0;
                arready_o = live_q && draw_ready();  // idle and free to take an address
            end else begin
                arready_o = 1'b0;  // one read outstanding
                // rvalid holds once raised until the beat is taken
                if (!rvalid_o && draw_ready()) begin
                    rvalid_o = 1'b1;
                    rdata_o  = read_word(pend_addr_q);
                    rresp_o  = in_err_window(pend_addr_q) ? 2'b10 : 2'b00;  // slverr
                end
            end
        end
    end

endmodule

/* source/icache_top.sv */
//##########################################################
// icache_top
// two-way read-only instruction cache, core fetch port
// on the front and an axi4-lite read master at the back
//##########################################################
`timescale 1ns/1ps

`include "icache_consts.svh"

module icache_top (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,
    // core fetch port
    input  logic                      req_valid_i,
    input  logic [`ICACHE_ADDR_W-1:0] req_addr_i,
    output logic                      req_ready_o,
    output logic                      resp_valid_o,
    output icache_pkg::word_t         resp_data_o,
    output logic                      resp_err_o,
    // axi4-lite read master
    output logic                      m_arvalid_o,
    input  logic                      m_arready_i,
    output logic [`ICACHE_ADDR_W-1:0] m_araddr_o,
    input  logic                      m_rvalid_i,
    output logic                      m_rready_o,
    input  icache_pkg::word_t         m_rdata_i,
    input  logic [1:0]                m_rresp_i
);

    import icache_pkg::*;

    logic                      ram_req;
    logic                      ram_we [`ICACHE_N_WAY];
    idx_t                      ram_idx;
    tag_t                      wr_tag;
    line_t                     wr_line;
    line_t                     way_line [`ICACHE_N_WAY];
    tag_t                      way_tag [`ICACHE_N_WAY];
    logic                      refill_start;
    logic [`ICACHE_ADDR_W-1:0] refill_addr;
    logic                      refill_done;
    logic                      refill_err;
    line_t                     refill_line;

    // data ways
    icache_way way0 (.clk_i(clk_i), .rst_n_i(rst_n_i), .req_i(ram_req), .we_i(ram_we[0]),
                     .addr_i(ram_idx), .data_i(wr_line), .data_o(way_line[0]));
    icache_way way1 (.clk_i(clk_i), .rst_n_i(rst_n_i), .req_i(ram_req), .we_i(ram_we[1]),
                     .addr_i(ram_idx), .data_i(wr_line), .data_o(way_line[1]));

    // tag arrays, same port timing as the ways
    set_ram #(.payload_t(tag_t), .DEPTH(`ICACHE_N_SET)) tag0 (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .req_i(ram_req), .we_i(ram_we[0]),
        .addr_i(ram_idx), .data_i(wr_tag), .data_o(way_tag[0]));
    set_ram #(.payload_t(tag_t), .DEPTH(`ICACHE_N_SET)) tag1 (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .req_i(ram_req), .we_i(ram_we[1]),
        .addr_i(ram_idx), .data_i(wr_tag), .data_o(way_tag[1]));

    icache_ctrl ctrl (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .flush_i(flush_i),
        .req_valid_i(req_valid_i), .req_addr_i(req_addr_i), .req_ready_o(req_ready_o),
        .resp_valid_o(resp_valid_o), .resp_data_o(resp_data_o), .resp_err_o(resp_err_o),
        .way_line_i(way_line), .tag_i(way_tag),
        .ram_req_o(ram_req), .ram_we_o(ram_we), .ram_idx_o(ram_idx),
        .wr_tag_o(wr_tag), .wr_line_o(wr_line),
        .refill_done_i(refill_done), .refill_err_i(refill_err),
        .refill_line_i(refill_line),
        .refill_start_o(refill_start), .refill_addr_o(refill_addr));

    icache_refill refill (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .start_i(refill_start), .line_addr_i(refill_addr),
        .done_o(refill_done), .err_o(refill_err), .line_o(refill_line),
        .m_arvalid_o(m_arvalid_o), .m_arready_i(m_arready_i), .m_araddr_o(m_araddr_o),
        .m_rvalid_i(m_rvalid_i), .m_rready_o(m_rready_o),
        .m_rdata_i(m_rdata_i), .m_rresp_i(m_rresp_i));

endmodule

/* icache/icache_refill.sv */
//##########################################################
// icache_refill
// axi4-lite read master, four single-beat reads per line
// packs the words and merges the response errors
//##########################################################
`timescale 1ns/1ps

`include "icache_consts.svh"

module icache_refill (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      start_i,
    input  logic [`ICACHE_ADDR_W-1:0] line_addr_i,
    output logic                      done_o,
    output logic                      err_o,
    output icache_pkg::line_t         line_o,
    // axi4-lite read channels
    output logic                      m_arvalid_o,
    input  logic                      m_arready_i,
    output logic [`ICACHE_ADDR_W-1:0] m_araddr_o,
    input  logic                      m_rvalid_i,
    output logic                      m_rready_o,
    input  icache_pkg::word_t         m_rdata_i,
    input  logic [1:0]                m_rresp_i
);

    import icache_pkg::*;

    localparam int BEAT_W = $clog2(`ICACHE_BEATS);

    logic [`ICACHE_ADDR_W-1:0] base_q;   // line base address
    logic [BEAT_W-1:0]         beat_q;   // current word of the line
    logic                      arvalid_q;
    logic                      rready_q;
    logic                      done_q;
    logic                      err_q;    // sticky over the line
    line_t                     line_q;
    logic                      r_hs;
    logic                      last;

    assign r_hs = m_rvalid_i && rready_q;
    assign last = (beat_q == BEAT_W'(`ICACHE_BEATS - 1));

    // beat k at base + 4k
    assign m_araddr_o  = {base_q[`ICACHE_ADDR_W-1:`ICACHE_OFF_W], beat_q, 2'b00};
    assign m_arvalid_o = arvalid_q;
    assign m_rready_o  = rready_q;
    assign done_o      = done_q;
    assign err_o       = err_q;
    assign line_o      = line_q;

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            base_q <= line_addr_i;
        end
        if (r_hs) begin
            line_q[beat_q*`ICACHE_WORD_W +: `ICACHE_WORD_W] <= m_rdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            beat_q    <= '0;
            arvalid_q <= 1'b0;
            rready_q  <= 1'b0;
            done_q    <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;  // single-cycle pulse
            if (start_i) begin
                beat_q    <= '0;
                err_q     <= 1'b0;
                arvalid_q <= 1'b1;
            end else if (arvalid_q && m_arready_i) begin
                arvalid_q <= 1'b0;  // address taken, wait for data
                rready_q  <= 1'b1;
            end else if (r_hs) begin
                rready_q <= 1'b0;
                err_q    <= err_q || (m_rresp_i != 2'b00);  // drain even on error
                if (last) begin
                    done_q <= 1'b1;
                end else begin
                    beat_q    <= beat_q + 1'b1;
                    arvalid_q <= 1'b1;  // next address
                end
            end
        end
    end

    // ar payload must hold until the slave takes it
    a_ar_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        m_arvalid_o && !m_arready_i |=> $stable(m_araddr_o))
        else $error("icache_refill: araddr changed while stalled");

endmodule

/* icache/icache_ctrl.sv */
//##########################################################
// icache_ctrl
// tag compare, valid and lru state, victim choice, flush
// and refill sequencing for the two-way cache
//##########################################################
`timescale 1ns/1ps

`include "icache_consts.svh"

module icache_ctrl (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,
    // core side
    input  logic                      req_valid_i,
    input  logic [`ICACHE_ADDR_W-1:0] req_addr_i,
    output logic                      req_ready_o,
    output logic                      resp_valid_o,
    output icache_pkg::word_t         resp_data_o,
    output logic                      resp_err_o,
    // way and tag rams
    input  icache_pkg::line_t         way_line_i [`ICACHE_N_WAY],
    input  icache_pkg::tag_t          tag_i [`ICACHE_N_WAY],
    output logic                      ram_req_o,
    output logic                      ram_we_o [`ICACHE_N_WAY],
    output icache_pkg::idx_t          ram_idx_o,
    output icache_pkg::tag_t          wr_tag_o,
    output icache_pkg::line_t         wr_line_o,
    // refill engine
    input  logic                      refill_done_i,
    input  logic                      refill_err_i,
    input  icache_pkg::line_t         refill_line_i,
    output logic                      refill_start_o,
    output logic [`ICACHE_ADDR_W-1:0] refill_addr_o
);

    import icache_pkg::*;

    localparam int WSEL_W = $clog2(`ICACHE_BEATS);

    logic [`ICACHE_ADDR_W-1:0] cmp_addr_q;          // address in compare stage
    logic                      cmp_valid_q;
    logic                      busy_q;              // refill outstanding
    logic                      victim_q;            // way being refilled
    logic                      flush_pend_q;        // flush held off by a miss
    logic [`ICACHE_N_SET-1:0]  vld_q [`ICACHE_N_WAY];
    logic [`ICACHE_N_SET-1:0]  lru_q;               // way to evict next

    idx_t                      cmp_idx;
    tag_t                      cmp_tag;
    logic [WSEL_W-1:0]         cmp_wsel;
    logic [`ICACHE_N_WAY-1:0]  hit_w;
    logic                      hit_way;
    logic                      miss;
    logic                      accept;
    logic                      install;
    logic                      flush_req;
    logic                      take_flush;
    logic                      victim;
    line_t                     src_line;

    assign cmp_idx  = cmp_addr_q[`ICACHE_OFF_W +: `ICACHE_IDX_W];
    assign cmp_tag  = cmp_addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign cmp_wsel = cmp_addr_q[`ICACHE_OFF_W-1 -: WSEL_W];

    // compare against registered ram outputs
    always_comb begin
        for (int w = 0; w < `ICACHE_N_WAY; w++) begin
            hit_w[w] = cmp_valid_q && vld_q[w][cmp_idx] && (tag_i[w] == cmp_tag);
        end
    end

    assign hit_way = hit_w[1];
    assign miss    = cmp_valid_q && !(|hit_w);

    // free way first, way 0 preferred, else lru
    assign victim = !vld_q[0][cmp_idx] ? 1'b0 :
                    !vld_q[1][cmp_idx] ? 1'b1 : lru_q[cmp_idx];

    assign flush_req   = flush_i || flush_pend_q;
    assign take_flush  = flush_req && !busy_q && !miss;
    assign req_ready_o = !busy_q && !miss && !flush_req;  // drops in the miss cycle
    assign accept      = req_valid_i && req_ready_o;
    assign install     = busy_q && refill_done_i && !refill_err_i;  // bad lines dropped

    // ram port shared by lookup reads and refill writes
    assign ram_req_o = accept || (busy_q && refill_done_i);
    assign ram_idx_o = busy_q ? cmp_idx : req_addr_i[`ICACHE_OFF_W +: `ICACHE_IDX_W];
    assign wr_tag_o  = cmp_tag;
    assign wr_line_o = refill_line_i;

    always_comb begin
        for (int w = 0; w < `ICACHE_N_WAY; w++) begin
            ram_we_o[w] = install && (victim_q == w[0]);
        end
    end

    assign refill_start_o = miss;
    assign refill_addr_o  = {cmp_tag, cmp_idx, {`ICACHE_OFF_W{1'b0}}};  // line base

    // response from hit way or from the fresh line
    assign src_line     = busy_q ? refill_line_i : way_line_i[hit_way];
    assign resp_data_o  = src_line[cmp_wsel*`ICACHE_WORD_W +: `ICACHE_WORD_W];
    assign resp_valid_o = (cmp_valid_q && (|hit_w)) || (busy_q && refill_done_i);
    assign resp_err_o   = busy_q && refill_done_i && refill_err_i;

    always_ff @(posedge clk_i) begin
        if (accept) begin
            cmp_addr_q <= req_addr_i;
        end
        if (miss) begin
            victim_q <= victim;  // held for the whole refill
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cmp_valid_q  <= 1'b0;
            busy_q       <= 1'b0;
            flush_pend_q <= 1'b0;
            vld_q        <= '{default: '0};
            lru_q        <= '0;
        end else begin
            cmp_valid_q  <= accept;
            flush_pend_q <= flush_req && !take_flush;
            if (miss) begin
                busy_q <= 1'b1;
            end else if (refill_done_i) begin
                busy_q <= 1'b0;
            end
            if (take_flush) begin
                vld_q <= '{default: '0};  // invalidate all
            end
            if (cmp_valid_q && (|hit_w)) begin
                lru_q[cmp_idx] <= ~hit_way;  // other way becomes lru
            end
            if (install) begin
                vld_q[victim_q][cmp_idx] <= 1'b1;
                lru_q[cmp_idx]           <= ~victim_q;
            end
        end
    end

    // two valid copies of one line would mean a broken install
    a_onehot_hit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(hit_w))
        else $error("icache_ctrl: both ways hit");

    // no new refill until the running one is done
    a_one_refill: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        refill_start_o |-> !busy_q)
        else $error("icache_ctrl: refill started while busy");

endmodule

/* icache/icache_way.sv */
//##########################################################
// icache_way
// line storage of one cache way, one line per set
// body is the spot for an sram macro swap
//##########################################################
`timescale 1ns/1ps

`include "icache_consts.svh"

module icache_way (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               req_i,
    input  logic               we_i,
    input  icache_pkg::idx_t   addr_i,
    input  icache_pkg::line_t  data_i,
    output icache_pkg::line_t  data_o
);

    import icache_pkg::*;

    // behavioral array, full line per access
    set_ram #(
        .payload_t (line_t),
        .DEPTH     (`ICACHE_N_SET)
    ) sram (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (req_i),    // chip enable
        .we_i    (we_i),     // line-wide write, no byte mask
        .addr_i  (addr_i),
        .data_i  (data_i),
        .data_o  (data_o)    // valid the cycle after a read request
    );

endmodule

/* source/set_ram.sv */
//##########################################################
// set_ram
// behavioral single-port synchronous ram, one entry per
// set, registered read, payload type set per instance
//##########################################################
`timescale 1ns/1ps

`include "icache_consts.svh"

module set_ram #(
    parameter type payload_t = logic [`ICACHE_LINE_W-1:0],
    parameter int  DEPTH     = `ICACHE_N_SET
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              req_i,
    input  logic              we_i,
    input  icache_pkg::idx_t  addr_i,
    input  payload_t          data_i,
    output payload_t          data_o
);

    payload_t mem [DEPTH];  // storage array

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            if (we_i) begin
                mem[addr_i] <= data_i;  // write, output keeps old value
            end else begin
                data_o <= mem[addr_i];  // read lands one edge later
            end
        end
    end

    // an x index would corrupt or read a random set
    a_addr_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_i |-> !$isunknown(addr_i))
        else $error("set_ram: unknown address with request");

endmodule

/* common/icache_pkg.sv */
//##########################################################
// icache package
// shared address-field, line and word types
//##########################################################

`include "icache_consts.svh"

package icache_pkg;

    // set index, bits 9:4 of the fetch address
    typedef logic [`ICACHE_IDX_W-1:0] idx_t;

    // tag, upper address bits above the index
    typedef logic [`ICACHE_TAG_W-1:0] tag_t;

    // one full cache line
    // word k sits at bits 32k and up
    typedef logic [`ICACHE_LINE_W-1:0] line_t;

    // one fetch word, same width as an axi read beat
    typedef logic [`ICACHE_WORD_W-1:0] word_t;

endpackage

/* common/icache_consts.svh */
//##########################################################
// icache constants
// cache geometry and fetch address field widths
//##########################################################
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// fetch address
`define ICACHE_ADDR_W 32

// geometry, lru is one bit so the ways stay at 2
`define ICACHE_N_SET  64
`define ICACHE_N_WAY  2
`define ICACHE_LINE_W 128
`define ICACHE_WORD_W 32  // also the axi beat width
`define ICACHE_BEATS  4   // words per line

// address split  tag | index | offset
`define ICACHE_IDX_W  6
`define ICACHE_OFF_W  4   // byte offset, word select at 3:2
`define ICACHE_TAG_W  22

`endif
